/* verilog.f */
logic/div_pkg.sv
logic/div_ctrl.sv
logic/div_iter_counter.sv
logic/div_operand_prep.sv
logic/div_shift_sub.sv
logic/div_result_sel.sv
logic/div_unit.sv
test/tb_div_unit.sv

/* Bender.yml */
package:
  name: div_unit

sources:
  # Shared types
  - files:
      - logic/div_pkg.sv

  # Divider RTL, top level last
  - files:
      - logic/div_ctrl.sv
      - logic/div_iter_counter.sv
      - logic/div_operand_prep.sv
      - logic/div_shift_sub.sv
      - logic/div_result_sel.sv
      - logic/div_unit.sv

  # Testbench
  - target: test
    files:
      - test/tb_div_unit.sv

/* test/tb_div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit
    import div_pkg::*;
;

    localparam int N            = 32;
    localparam int HOLD_TIMEOUT = 100;

    localparam logic [N-1:0] MIN_NEG = {1'b1, {(N-1){1'b0}}};

    logic         clk = 1'b0;
    logic         reset_n;
    logic         enable_i;
    div_op_e      op_i;
    logic [N-1:0] first_operand_i;
    logic [N-1:0] second_operand_i;
    logic         hold_o;
    logic [N-1:0] result_o;

    logic [31:0]  lfsr_state = 32'hb35630f8;

    always #10 clk = ~clk;

    div_unit #(.N(N)) i_dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable_i         (enable_i),
        .op_i             (op_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .hold_o           (hold_o),
        .result_o         (result_o)
    );

    // ******************************************************************
    // Failure handling and compare tasks
    // ******************************************************************

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_result(input div_op_e op, input logic [N-1:0] expected,
                                input logic [N-1:0] actual);
        if (actual !== expected) begin
            $display("ERR t=%0t result_o (%s) expected=%h actual=%h",
                     $time, op.name(), expected, actual);
            stop_on_failure("result mismatch");
        end
    endtask

    task automatic check_hold_cycles(input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR t=%0t hold_o cycles expected=%0d actual=%0d",
                     $time, expected, actual);
            stop_on_failure("wrong number of hold cycles");
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            stop_on_failure("signal level mismatch");
        end
    endtask

    // ******************************************************************
    // Reference model and random source
    // ******************************************************************

    // RISC-V M rules, truncating division, remainder signed like the dividend
    function automatic logic [N-1:0] model_result(input div_op_e op, input logic [N-1:0] a,
                                                  input logic [N-1:0] b);
        logic signed [N-1:0] sa;
        logic signed [N-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            OP_DIV: begin
                if (b == '0) return '1;
                if (a == MIN_NEG && b == '1) return a;
                return sa / sb;
            end
            OP_REM: begin
                if (b == '0) return a;
                if (a == MIN_NEG && b == '1) return '0;
                return sa % sb;
            end
            OP_DIVU: begin
                if (b == '0) return '1;
                return a / b;
            end
            default: begin
                if (b == '0) return a;
                return a % b;
            end
        endcase
    endfunction

    // Special cases answer in the start cycle, others iterate once per bit
    function automatic int model_hold_cycles(input div_op_e op, input logic [N-1:0] a,
                                             input logic [N-1:0] b);
        logic is_signed;
        is_signed = (op == OP_DIV) || (op == OP_REM);
        if (b == '0 || b == 1) return 1;
        if (is_signed && a == MIN_NEG && b == '1) return 1;
        return N + 3;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // ******************************************************************
    // Division driver
    // ******************************************************************

    task automatic run_div(input div_op_e op, input logic [N-1:0] a,
                           input logic [N-1:0] b, input int linger);
        logic [N-1:0] expected;
        int           exp_cycles;
        int           cycles;
        logic         released;
        expected   = model_result(op, a, b);
        exp_cycles = model_hold_cycles(op, a, b);
        @(posedge clk);
        enable_i         <= 1'b1;
        op_i             <= op;
        first_operand_i  <= a;
        second_operand_i <= b;
        cycles   = 0;
        released = 1'b0;
        while (!released) begin
            @(negedge clk);
            if (hold_o) begin
                cycles++;
                if (cycles > HOLD_TIMEOUT) begin
                    stop_on_failure($sformatf("hold never released for %s %h / %h",
                                              op.name(), a, b));
                end
            end else begin
                released = 1'b1;
            end
        end
        check_hold_cycles(exp_cycles, cycles);
        check_result(op, expected, result_o);
        // Result must stay put and no restart while enable stays high
        repeat (linger) begin
            @(negedge clk);
            check_level("hold_o", 1'b0, hold_o);
            check_result(op, expected, result_o);
        end
        @(posedge clk);
        enable_i <= 1'b0;
    endtask

    task automatic run_all_ops(input logic [N-1:0] a, input logic [N-1:0] b);
        int i;
        for (i = 0; i < 4; i++) begin
            run_div(div_op_e'(i), a, b, 0);
        end
    endtask

    // ******************************************************************
    // Directed tests
    // ******************************************************************

    task automatic test_reset_idle();
        repeat (3) begin
            @(negedge clk);
            check_level("hold_o", 1'b0, hold_o);
        end
    endtask

    task automatic test_fixed_values();
        run_all_ops(32'd100, 32'd7);
        run_all_ops(-32'sd100, 32'd7);
        run_all_ops(32'd100, -32'sd7);
        run_all_ops(-32'sd100, -32'sd7);
        run_all_ops(32'hFFFF_FFFF, 32'd3);
        run_all_ops(MIN_NEG, 32'd2);
        run_all_ops(32'd5, 32'd100);
        run_all_ops(32'd12345678, 32'd12345678);
    endtask

    task automatic test_special_cases();
        run_all_ops(32'h1234_5678, '0);
        run_all_ops(-32'sd5, '0);
        run_all_ops(32'h8765_4321, 32'd1);
        run_all_ops(-32'sd77, 32'd1);
    endtask

    task automatic test_overflow();
        run_div(OP_DIV, MIN_NEG, '1, 0);
        run_div(OP_REM, MIN_NEG, '1, 0);
        // Unsigned opcodes take the normal path
        run_div(OP_DIVU, MIN_NEG, '1, 0);
        run_div(OP_REMU, MIN_NEG, '1, 0);
    endtask

    task automatic test_hold_after_done();
        run_div(OP_DIV, -32'sd1000, 32'd33, 6);
        run_div(OP_REM, 32'd1000, -32'sd33, 6);
        run_div(OP_DIVU, 32'd42, '0, 4);
        run_div(OP_REMU, 32'd99999, 32'd17, 2);
    endtask

    task automatic test_random_pairs();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sel;
        logic [31:0] shift;
        int          n;
        for (n = 0; n < 200; n++) begin
            random_bits(32, a);
            random_bits(32, b);
            random_bits(2, sel);
            random_bits(2, shift);
            // Smaller divisors now and then for longer quotients
            if (shift[1:0] == 2'd0) begin
                b = b >> 24;
            end else if (shift[1:0] == 2'd1) begin
                random_bits(5, shift);
                b = b >> shift[4:0];
            end
            run_div(div_op_e'(sel[1:0]), a, b, 1);
        end
    endtask

    // ******************************************************************
    // Main sequence
    // ******************************************************************

    initial begin
        reset_n          = 1'b0;
        enable_i         = 1'b0;
        op_i             = OP_DIV;
        first_operand_i  = '0;
        second_operand_i = '0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_idle();
        test_fixed_values();
        test_special_cases();
        test_overflow();
        test_hold_after_done();
        test_random_pairs();

        repeat (2) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit
    import div_pkg::*;
#(
    parameter int N = 32
) (
    input  logic         clk,
    input  logic         reset_n,

    input  logic         enable_i,
    input  div_op_e      op_i,
    input  logic [N-1:0] first_operand_i,
    input  logic [N-1:0] second_operand_i,

    output logic         hold_o,
    output logic [N-1:0] result_o
);

    // Controller strobes
    logic         load;
    logic         init;
    logic         step;
    logic         latch_sign;
    logic         count_clear;
    logic         last;

    // Special-case flags
    logic         div_by_zero;
    logic         div_by_one;
    logic         overflow;

    // Datapath
    logic [N-1:0] dividend_mag;
    logic [N-1:0] divisor_mag;
    logic         dividend_neg;
    logic         quotient_neg;
    logic [N-1:0] quotient;
    logic [N-1:0] remainder_mag;

    // ******************************************************************
    // Control
    // ******************************************************************

    div_ctrl i_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .div_by_zero_i (div_by_zero),
        .div_by_one_i  (div_by_one),
        .overflow_i    (overflow),
        .last_i        (last),
        .load_o        (load),
        .init_o        (init),
        .step_o        (step),
        .latch_sign_o  (latch_sign),
        .count_clear_o (count_clear),
        .hold_o        (hold_o)
    );

    // Counts once per quotient bit
    div_iter_counter #(.N(N)) i_counter (
        .clk     (clk),
        .reset_n (reset_n),
        .clear_i (count_clear),
        .count_i (step),
        .last_o  (last)
    );

    // ******************************************************************
    // Datapath
    // ******************************************************************

    div_operand_prep #(.N(N)) i_prep (
        .clk              (clk),
        .reset_n          (reset_n),
        .load_i           (load),
        .op_i             (op_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .dividend_mag_o   (dividend_mag),
        .divisor_mag_o    (divisor_mag),
        .dividend_neg_o   (dividend_neg),
        .quotient_neg_o   (quotient_neg),
        .div_by_zero_o    (div_by_zero),
        .div_by_one_o     (div_by_one),
        .overflow_o       (overflow)
    );

    div_shift_sub #(.N(N)) i_shift_sub (
        .clk             (clk),
        .reset_n         (reset_n),
        .init_i          (init),
        .step_i          (step),
        .dividend_mag_i  (dividend_mag),
        .divisor_mag_i   (divisor_mag),
        .quotient_o      (quotient),
        .remainder_mag_o (remainder_mag)
    );

    div_result_sel #(.N(N)) i_result_sel (
        .clk             (clk),
        .reset_n         (reset_n),
        .latch_sign_i    (latch_sign),
        .op_i            (op_i),
        .first_operand_i (first_operand_i),
        .quotient_i      (quotient),
        .remainder_mag_i (remainder_mag),
        .dividend_neg_i  (dividend_neg),
        .quotient_neg_i  (quotient_neg),
        .div_by_zero_i   (div_by_zero),
        .div_by_one_i    (div_by_one),
        .overflow_i      (overflow),
        .result_o        (result_o)
    );

endmodule

`default_nettype wire

/* logic/div_result_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_sel
    import div_pkg::*;
#(
    parameter int N = 32
) (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         latch_sign_i,

    input  div_op_e      op_i,
    input  logic [N-1:0] first_operand_i,

    input  logic [N-1:0] quotient_i,
    input  logic [N-1:0] remainder_mag_i,
    input  logic         dividend_neg_i,
    input  logic         quotient_neg_i,

    input  logic         div_by_zero_i,
    input  logic         div_by_one_i,
    input  logic         overflow_i,

    output logic [N-1:0] result_o
);

    logic [N-1:0] quotient_q;
    logic [N-1:0] remainder;
    logic [N-1:0] quo_result;
    logic [N-1:0] rem_result;

    // ******************************************************************
    // Sign correction
    // ******************************************************************

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            quotient_q <= '0;
        end else if (latch_sign_i) begin
            quotient_q <= quotient_neg_i ? -quotient_i : quotient_i;
        end
    end

    // Remainder follows the sign of the dividend
    assign remainder = dividend_neg_i ? -remainder_mag_i : remainder_mag_i;

    // ******************************************************************
    // Special results and output select
    // ******************************************************************

    always_comb begin
        quo_result = quotient_q;
        rem_result = remainder;
        if (div_by_zero_i) begin
            quo_result = '1;
            rem_result = first_operand_i;
        end else if (div_by_one_i || overflow_i) begin
            quo_result = first_operand_i;
            rem_result = '0;
        end
    end

    always_comb begin
        case (op_i)
            OP_DIV, OP_DIVU: result_o = quo_result;
            default:         result_o = rem_result;
        endcase
    end

endmodule

`default_nettype wire

/* logic/div_shift_sub.sv */
`timescale 1ns/1ps
`default_nettype none

module div_shift_sub #(
    parameter int N = 32
) (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         init_i,
    input  logic         step_i,

    input  logic [N-1:0] dividend_mag_i,
    input  logic [N-1:0] divisor_mag_i,

    output logic [N-1:0] quotient_o,
    output logic [N-1:0] remainder_mag_o
);

    logic [N:0]   acc;
    logic [N:0]   acc_diff;
    logic [N:0]   next_acc;
    logic [N-1:0] quo;
    logic [N-1:0] next_quo;
    logic         fits;

    // Trial subtraction
    assign fits     = (acc >= {1'b0, divisor_mag_i});
    assign acc_diff = acc - {1'b0, divisor_mag_i};

    // Restore on no fit, then shift the pair left by one
    always_comb begin
        if (fits) begin
            {next_acc, next_quo} = {acc_diff[N-1:0], quo, 1'b1};
        end else begin
            {next_acc, next_quo} = {acc[N-1:0], quo, 1'b0};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc <= '0;
            quo <= '0;
        end else if (init_i) begin
            // Dividend MSB lands in the accumulator LSB
            {acc, quo} <= {{N{1'b0}}, dividend_mag_i, 1'b0};
        end else if (step_i) begin
            acc <= next_acc;
            quo <= next_quo;
        end
    end

    assign quotient_o      = quo;
    assign remainder_mag_o = acc[N:1];

endmodule

`default_nettype wire

/* logic/div_operand_prep.sv */
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep
    import div_pkg::*;
#(
    parameter int N = 32
) (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         load_i,

    input  div_op_e      op_i,
    input  logic [N-1:0] first_operand_i,
    input  logic [N-1:0] second_operand_i,

    output logic [N-1:0] dividend_mag_o,
    output logic [N-1:0] divisor_mag_o,
    output logic         dividend_neg_o,
    output logic         quotient_neg_o,

    output logic         div_by_zero_o,
    output logic         div_by_one_o,
    output logic         overflow_o
);

    localparam logic [N-1:0] ONE     = {{(N-1){1'b0}}, 1'b1};
    localparam logic [N-1:0] MIN_NEG = {1'b1, {(N-1){1'b0}}};

    logic signed_op;
    logic sign_a;
    logic sign_b;

    // ******************************************************************
    // Sign decode
    // ******************************************************************

    assign signed_op = (op_i == OP_DIV) || (op_i == OP_REM);

    assign sign_a = first_operand_i[N-1] & signed_op;
    assign sign_b = second_operand_i[N-1] & signed_op;

    // ******************************************************************
    // Special cases, from live operands
    // ******************************************************************

    assign div_by_zero_o = (second_operand_i == '0);
    assign div_by_one_o  = (second_operand_i == ONE);
    // Most negative value divided by minus one
    assign overflow_o    = signed_op && (second_operand_i == '1) &&
                           (first_operand_i == MIN_NEG);

    // ******************************************************************
    // Operand registers
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (load_i) begin
            dividend_mag_o <= sign_a ? -first_operand_i : first_operand_i;
            divisor_mag_o  <= sign_b ? -second_operand_i : second_operand_i;
        end
    end

    // Sign facts needed later for result correction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dividend_neg_o <= 1'b0;
            quotient_neg_o <= 1'b0;
        end else if (load_i) begin
            dividend_neg_o <= sign_a;
            quotient_neg_o <= sign_a ^ sign_b;
        end
    end

endmodule

`default_nettype wire

/* logic/div_iter_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module div_iter_counter #(
    parameter int N = 32
) (
    input  logic clk,
    input  logic reset_n,
    input  logic clear_i,
    input  logic count_i,
    output logic last_o
);

    // One count per quotient bit
    localparam int CW = (N > 1) ? $clog2(N) : 1;

    logic [CW-1:0] count;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (clear_i) begin
            count <= '0;
        end else if (count_i) begin
            count <= count + 1'b1;
        end
    end

    // High during the Nth counted cycle
    assign last_o = count_i && (count == CW'(N - 1));

endmodule

`default_nettype wire

/* logic/div_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module div_ctrl
    import div_pkg::*;
(
    input  logic clk,
    input  logic reset_n,
    input  logic enable_i,

    input  logic div_by_zero_i,
    input  logic div_by_one_i,
    input  logic overflow_i,

    input  logic last_i,

    output logic load_o,
    output logic init_o,
    output logic step_o,
    output logic latch_sign_o,
    output logic count_clear_o,
    output logic hold_o
);

    div_states_e state;
    logic        busy;
    logic        result_pending;
    logic        start;
    logic        special;

    // ******************************************************************
    // Start decision
    // ******************************************************************

    // Special cases are answered without iterating
    assign special = div_by_zero_i | div_by_one_i | overflow_i;
    assign start   = enable_i & ~busy & ~result_pending;

    // ******************************************************************
    // Strobes
    // ******************************************************************

    assign load_o        = start & ~special;
    assign init_o        = (state == D_INIT);
    assign count_clear_o = (state == D_INIT);
    assign step_o        = (state == D_CALC);
    assign latch_sign_o  = (state == D_SIGN);

    assign hold_o = start | busy;

    // ******************************************************************
    // State register
    // ******************************************************************

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= D_IDLE;
            busy  <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (load_o) begin
                        state <= D_INIT;
                        busy  <= 1'b1;
                    end
                end
                D_INIT: begin
                    state <= D_CALC;
                end
                D_CALC: begin
                    // Counter flags the final quotient bit
                    if (last_i) begin
                        state <= D_SIGN;
                    end
                end
                D_SIGN: begin
                    state <= D_IDLE;
                    busy  <= 1'b0;
                end
                default: begin
                    state <= D_IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // Result stays pending until the requester drops enable
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_pending <= 1'b0;
        end else if (!enable_i) begin
            result_pending <= 1'b0;
        end else if ((start & special) | latch_sign_o) begin
            result_pending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/div_pkg.sv */
`default_nettype none

package div_pkg;

    // ******************************************************************
    // Divider FSM states
    // ******************************************************************

    typedef enum logic [1:0] {
        D_IDLE = 2'b00,
        D_INIT = 2'b01,
        D_CALC = 2'b10,
        D_SIGN = 2'b11
    } div_states_e;

    // ******************************************************************
    // Divide opcodes
    // ******************************************************************

    // Low two bits of the RV32M funct3 field
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

endpackage

`default_nettype wire
